/* lineBuffer.sv */
`timescale 1ns/100ps
`default_nettype none

// One line buffer RAM
// Write and read in the same cycle, read data one cycle later
module lineBuffer (
	input wire CLK_1MB,
	input wire we,
	input wire [7:0] wAddr,
	input wire neoVideoPkg::lbEntry_t wData,
	input wire [7:0] rAddr,
	output neoVideoPkg::lbEntry_t rData
);

	neoVideoPkg::lbEntry_t mem [neoVideoPkg::LB_DEPTH];	// One entry per column

	always_ff @(posedge CLK_1MB)
	begin
		if (we)
			mem[wAddr] <= wData;
		rData <= mem[rAddr];	// Old data on a same-address write
	end

endmodule

`default_nettype wire

/* lineBufferAddr.sv */
`timescale 1ns/100ps
`default_nettype none

// Column counter for one line buffer
// Serves both the render side and the display side
module lineBufferAddr (
	input wire CLK_1MB,
	input wire ld,	// Load start column
	input wire en,	// Step to next column
	input wire [7:0] loadVal,
	output logic [7:0] addr
);

	logic [7:0] addrNext;	// Incremented column
	logic atEnd;	// Last column of the line

	assign atEnd = (addr == 8'(neoVideoPkg::LB_DEPTH - 1));
	assign addrNext = atEnd ? 8'd0 : addr + 8'd1;	// Wraps to column 0

	// Load wins over count
	always_ff @(posedge CLK_1MB)
	begin
		if (ld)
			addr <= loadVal;
		else if (en)
			addr <= addrNext;
	end

endmodule

`default_nettype wire

/* neoB1Top.sv */
`timescale 1ns/100ps
`default_nettype none

module neoB1Top (
	input wire CLK_1MB,
	input wire rst,
	input wire neoVideoPkg::pbusWord_t pbus,
	input wire [7:0] fixd,
	input wire pck1,
	input wire pck2,
	input wire [3:0] gad,
	input wire [3:0] gbd,
	input wire ldA,
	input wire ldB,
	input wire weA,
	input wire weB,
	input wire rd,
	input wire bflip,
	input wire s1h1,
	input wire chbl,
	input wire neoVideoPkg::cpuBus_t cpu,
	output logic [11:0] pa,
	output logic nReset
);

	neoVideoPkg::palRegs_t regs;	// Latched PBUS fields
	neoVideoPkg::lbEntry_t sprPix;	// Sprite readout

	paletteLatch uLatch (
		.CLK_1MB(CLK_1MB),
		.rst(rst),
		.pbus(pbus),
		.pck1(pck1),
		.pck2(pck2),
		.regs(regs)
	);

	spriteLineBuffers uLb (
		.CLK_1MB(CLK_1MB),
		.rst(rst),
		.regs(regs),
		.gad(gad),
		.gbd(gbd),
		.ldA(ldA),
		.ldB(ldB),
		.weA(weA),
		.weB(weB),
		.rd(rd),
		.bflip(bflip),
		.s1h1(s1h1),
		.sprPix(sprPix)
	);

	pixelMixer uMix (
		.CLK_1MB(CLK_1MB),
		.rst(rst),
		.regs(regs),
		.fixd(fixd),
		.s1h1(s1h1),
		.sprPix(sprPix),
		.chbl(chbl),
		.cpu(cpu),
		.pa(pa)
	);

	watchdog uWd (
		.CLK_1MB(CLK_1MB),
		.rst(rst),
		.cpu(cpu),
		.nReset(nReset)
	);

endmodule

`default_nettype wire

/* neoVideoPkg.sv */
`default_nettype none

package neoVideoPkg;

	// Line buffer geometry
	localparam int LB_DEPTH = 256;	// Entries per buffer, one per pixel column
	localparam logic [11:0] BACKDROP = 12'hFFF;	// Value left behind by the erase

	// Fix layer lines up with the sprite readout after this many stages
	localparam int FIX_DELAY = 2;

	// Watchdog timing in CLK_1MB cycles
	localparam logic [11:0] WD_TIMEOUT = 12'd3000;
	localparam logic [3:0] WD_PULSE = 4'd8;	// Reset pulse length

	// CPU decode
	localparam logic [1:0] PAL_BASE_HI = 2'b01;	// A23/A22 of palette space
	// {a23, a22, addrU, addrL} of the kick register, byte $300001
	localparam logic [18:0] WD_KICK_ADDR = {2'b00, 5'b11000, 12'h000};

	// One line buffer word
	typedef struct packed {
		logic [7:0] pal;	// Sprite palette number
		logic [3:0] color;	// Pixel color index
	} lbEntry_t;

	// PBUS word, decoded by the strobe that announces it
	typedef union packed {
		struct packed {
			logic [7:0] pal;	// PBUS[23:16]
			logic [7:0] x;	// PBUS[15:8]
			logic [7:0] unused;
		} spr;
		struct packed {
			logic [3:0] unused;
			logic [3:0] pal;	// PBUS[19:16]
			logic [15:0] unusedLo;
		} fix;
	} pbusWord_t;

	// Values held from PBUS
	typedef struct packed {
		logic [7:0] sprPal;	// Already aligned with the pixel pair
		logic [3:0] fixPal;
		logic [7:0] xLoad;	// Line buffer start column
	} palRegs_t;

	// CPU address and strobes seen by the chip
	typedef struct packed {
		logic a23;
		logic a22;
		logic [4:0] addrU;	// A21..A17
		logic [11:0] addrL;	// A12..A1
		logic nAs;
		logic nLds;
		logic rw;	// High for read
	} cpuBus_t;

endpackage

`default_nettype wire

/* paletteLatch.sv */
`timescale 1ns/100ps
`default_nettype none

module paletteLatch (
	input wire CLK_1MB,
	input wire rst,
	input wire neoVideoPkg::pbusWord_t pbus,	// Shared parameter bus
	input wire pck1,	// Sprite word present
	input wire pck2,	// Fix word present
	output neoVideoPkg::palRegs_t regs
);

	logic lastSpr;	// Sprite word announced last
	logic [7:0] sprPalQ;	// First sprite palette stage
	logic [7:0] sprPalQQ;	// Lined up with gad/gbd
	logic [3:0] fixPalQ;
	logic [7:0] xLoadQ;

	// Word kind flag, sprite wins if both strobes come together
	always_ff @(posedge CLK_1MB)
	begin
		if (rst)
			lastSpr <= 1'b0;
		else if (pck1)
			lastSpr <= 1'b1;
		else if (pck2)
			lastSpr <= 1'b0;
	end

	// Fields picked out of the view that matches the strobe
	always_ff @(posedge CLK_1MB)
	begin
		if (pck1)
		begin
			sprPalQ <= pbus.spr.pal;
			xLoadQ <= pbus.spr.x;	// Start column for the next sprite
		end
		if (pck2)
			fixPalQ <= pbus.fix.pal;
		// Second stage only moves while the sprite word is current
		if (lastSpr)
			sprPalQQ <= sprPalQ;
	end

	assign regs.sprPal = sprPalQQ;
	assign regs.fixPal = fixPalQ;
	assign regs.xLoad = xLoadQ;

endmodule

`default_nettype wire

/* pixelMixer.sv */
`timescale 1ns/100ps
`default_nettype none

module pixelMixer (
	input wire CLK_1MB,
	input wire rst,
	input wire neoVideoPkg::palRegs_t regs,
	input wire [7:0] fixd,	// Two fix pixels
	input wire s1h1,
	input wire neoVideoPkg::lbEntry_t sprPix,
	input wire chbl,	// Forces PA to zero
	input wire neoVideoPkg::cpuBus_t cpu,
	output logic [11:0] pa	// Palette address bus
);

	// {s1h1, fixd}, the PA register is the last delay stage
	logic [8:0] fixPipe [neoVideoPkg::FIX_DELAY - 1];
	logic [8:0] fixLate;
	logic [3:0] fixColor;
	logic cpuPal;	// CPU owns the palette bus
	logic [11:0] videoPa;

	always_ff @(posedge CLK_1MB)
	begin
		fixPipe[0] <= {s1h1, fixd};
		for (int i = 1; i < neoVideoPkg::FIX_DELAY - 1; i++)
			fixPipe[i] <= fixPipe[i - 1];
	end

	assign fixLate = fixPipe[neoVideoPkg::FIX_DELAY - 2];
	assign fixColor = fixLate[8] ? fixLate[3:0] : fixLate[7:4];	// Low nibble on odd

	// Color 0 is transparent, sprite shows through
	assign videoPa = (fixColor != 4'd0) ? {4'h0, regs.fixPal, fixColor}
		: {sprPix.pal, sprPix.color};

	// $400000-$7FFFFF
	assign cpuPal = ({cpu.a23, cpu.a22} == neoVideoPkg::PAL_BASE_HI) & ~cpu.nAs;

	// CPU first, then blanking, then video
	always_ff @(posedge CLK_1MB)
	begin
		if (rst)
			pa <= 12'h000;
		else if (cpuPal)
			pa <= cpu.addrL;
		else if (chbl)
			pa <= 12'h000;
		else
			pa <= videoPa;
	end

endmodule

`default_nettype wire

/* sources.f */
neoVideoPkg.sv
paletteLatch.sv
lineBufferAddr.sv
lineBuffer.sv
spriteLineBuffers.sv
pixelMixer.sv
watchdog.sv
neoB1Top.sv
tbNeoB1.sv

/* spriteLineBuffers.sv */
`timescale 1ns/100ps
`default_nettype none

// Buffer index {set, half}: set 1 is B, half 1 is odd
module spriteLineBuffers (
	input wire CLK_1MB,
	input wire rst,
	input wire neoVideoPkg::palRegs_t regs,
	input wire [3:0] gad,	// Even pixel
	input wire [3:0] gbd,	// Odd pixel
	input wire ldA,
	input wire ldB,
	input wire weA,
	input wire weB,
	input wire rd,	// Display read strobe
	input wire bflip,	// Low renders A and shows B
	input wire s1h1,	// Odd half when high
	output neoVideoPkg::lbEntry_t sprPix
);

	logic [7:0] bufAddr [4];	// Column counter per buffer
	neoVideoPkg::lbEntry_t bufData [4];	// RAM read data per buffer
	logic sweepOn;	// Clear sweep after reset
	logic [7:0] sweepCnt;
	logic [1:0] dispIdx;	// Buffer being read this cycle
	logic clrValid;	// Entry read last cycle needs erasing
	logic [1:0] clrIdx;	// Buffer read last cycle
	logic [7:0] clrAddr;	// Column read last cycle

	assign dispIdx = {~bflip, s1h1};

	// Clears all four buffers at once
	always_ff @(posedge CLK_1MB)
	begin
		if (rst)
		begin
			sweepOn <= 1'b1;
			sweepCnt <= 8'd0;
		end
		else if (sweepOn)
		begin
			sweepCnt <= sweepCnt + 8'd1;
			if (sweepCnt == 8'(neoVideoPkg::LB_DEPTH - 1))
				sweepOn <= 1'b0;
		end
	end

	always_ff @(posedge CLK_1MB)
	begin
		if (rst)
			clrValid <= 1'b0;
		else
			clrValid <= rd & ~sweepOn;
	end

	// Read position, also selects the readout
	always_ff @(posedge CLK_1MB)
	begin
		clrIdx <= dispIdx;
		clrAddr <= bufAddr[dispIdx];
	end

	for (genvar i = 0; i < 4; i++)
	begin : gBuf
		logic isWrite;	// In the rendered set
		logic setLd;
		logic setWe;
		logic cntEn;
		logic [7:0] loadVal;
		logic doWrite;
		logic doClear;	// Erase behind the readout
		logic [7:0] wAddr;
		neoVideoPkg::lbEntry_t wData;

		assign isWrite = ((i >= 2) == bflip);
		assign setLd = (i >= 2) ? ldB : ldA;
		assign setWe = (i >= 2) ? weB : weA;
		// Display side steps only the half being shown
		assign cntEn = isWrite ? setWe : (rd & (s1h1 == (i % 2 == 1)));
		assign loadVal = (i % 2 == 1) ? regs.xLoad : regs.xLoad + 8'd1;	// Even leads by one
		assign doWrite = isWrite & setWe & ~sweepOn;
		assign doClear = clrValid & (clrIdx == 2'(i)) & ~doWrite;
		assign wAddr = sweepOn ? sweepCnt : (doWrite ? bufAddr[i] : clrAddr);
		assign wData.pal = doWrite ? regs.sprPal : neoVideoPkg::BACKDROP[11:4];
		assign wData.color = doWrite ? ((i % 2 == 1) ? gbd : gad) : neoVideoPkg::BACKDROP[3:0];

		lineBufferAddr uCnt (
			.CLK_1MB(CLK_1MB),
			.ld(setLd),
			.en(cntEn),
			.loadVal(loadVal),
			.addr(bufAddr[i])
		);

		lineBuffer uRam (
			.CLK_1MB(CLK_1MB),
			.we(sweepOn | doWrite | doClear),
			.wAddr(wAddr),
			.wData(wData),
			.rAddr(bufAddr[i]),
			.rData(bufData[i])
		);
	end

	assign sprPix = bufData[clrIdx];	// Matches the RAM latency

endmodule

`default_nettype wire

/* tbNeoB1.sv */
`timescale 1ns/100ps
`default_nettype none

module tbNeoB1;

	logic CLK_1MB = 1'b0;
	logic rst;
	neoVideoPkg::pbusWord_t pbus;
	logic [7:0] fixd;
	logic pck1, pck2, ldA, ldB, weA, weB, rd, bflip, s1h1, chbl;
	logic [3:0] gad, gbd;
	neoVideoPkg::cpuBus_t cpu;
	logic [11:0] pa;
	logic nReset;

	integer seed;	// Pixel and address source
	int paErrors, entryErrors, resetErrors;
	int testCount = 5;	// Sizes the run limit
	logic [3:0] evenPix [16];	// Last written gad values
	logic [3:0] oddPix [16];	// Last written gbd values

	neoB1Top i_dut (
		.CLK_1MB(CLK_1MB),
		.rst(rst),
		.pbus(pbus),
		.fixd(fixd),
		.pck1(pck1),
		.pck2(pck2),
		.gad(gad),
		.gbd(gbd),
		.ldA(ldA),
		.ldB(ldB),
		.weA(weA),
		.weB(weB),
		.rd(rd),
		.bflip(bflip),
		.s1h1(s1h1),
		.chbl(chbl),
		.cpu(cpu),
		.pa(pa),
		.nReset(nReset)
	);

	always #50 CLK_1MB = ~CLK_1MB;	// 100 ns period

	// Run limit, tests plus three watchdog periods
	initial
	begin
		#((testCount * 600 + 3 * int'(neoVideoPkg::WD_TIMEOUT)) * 100);
		$display("Simulation timed out before all tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// Next drive point, 10 ns after the rising edge
	task automatic stepCycle();
		@(posedge CLK_1MB);
		#10;
	endtask

	task automatic setIdle();
		{pck1, pck2, ldA, ldB, weA, weB, rd, s1h1, chbl} = '0;
		gad = 4'h0;
		gbd = 4'h0;
		fixd = 8'h00;
		cpu = '0;
		cpu.nAs = 1'b1;	// No bus cycle
		cpu.nLds = 1'b1;
		cpu.rw = 1'b1;
	endtask

	task automatic checkPa(input logic [11:0] got, input logic [11:0] exp, input string what);
		if (got !== exp)
		begin
			paErrors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkEntry(input neoVideoPkg::lbEntry_t got,
		input neoVideoPkg::lbEntry_t exp, input string what);
		if (got !== exp)
		begin
			entryErrors++;
			$display("Error at %0t: %s is pal %h color %h, expected pal %h color %h",
				$time, what, got.pal, got.color, exp.pal, exp.color);
		end
	endtask

	task automatic expectReset(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			resetErrors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Sprite word on PBUS, then wait out the second palette stage
	task automatic sendSprite(input logic [7:0] pal, input logic [7:0] x);
		pbus = '0;
		pbus.spr.pal = pal;
		pbus.spr.x = x;
		pck1 = 1'b1;
		stepCycle();
		pck1 = 1'b0;
		stepCycle();
	endtask

	task automatic sendFix(input logic [3:0] pal);
		pbus = '0;
		pbus.fix.pal = pal;
		pck2 = 1'b1;
		stepCycle();
		pck2 = 1'b0;
	endtask

	task automatic loadCounters(input bit setB);
		ldA = ~setB;
		ldB = setB;
		stepCycle();
		ldA = 1'b0;
		ldB = 1'b0;
	endtask

	// Load then write 16 random pixel pairs into one set
	task automatic writeLine(input bit setB);
		loadCounters(setB);
		for (int k = 0; k < 16; k++)
		begin
			evenPix[k] = 4'($random(seed));
			oddPix[k] = 4'($random(seed));
			gad = evenPix[k];
			gbd = oddPix[k];
			weA = ~setB;
			weB = setB;
			stepCycle();
		end
		weA = 1'b0;
		weB = 1'b0;
		stepCycle();
	endtask

	// 32 reads, even/odd alternating, PA checked two cycles after each read
	task automatic readLine(input logic [7:0] pal, input bit erased, input bit withFix,
		input logic [3:0] fPal);
		neoVideoPkg::lbEntry_t expEntry [32];
		logic [11:0] expPa [32];
		neoVideoPkg::lbEntry_t gotEntry;
		logic [7:0] fixByte;
		logic [3:0] fixNib;
		for (int k = 0; k < 34; k++)
		begin
			if (k >= 2)
			begin
				gotEntry = pa;
				if (erased)
					checkPa(pa, expPa[k - 2], "erased PA");
				else if (withFix)
					checkPa(pa, expPa[k - 2], "mixed PA");
				else
					checkEntry(gotEntry, expEntry[k - 2], "sprite PA");
			end
			if (k < 32)
			begin
				fixByte = 8'h00;
				if (withFix)
				begin
					fixByte = 8'($random(seed));
					if (k % 3 == 0)
						fixByte[7:4] = 4'h0;	// Transparent even fix pixel
					if (k % 4 == 1)
						fixByte[3:0] = 4'h0;
				end
				fixNib = (k % 2 == 1) ? fixByte[3:0] : fixByte[7:4];	// Odd uses low nibble
				expEntry[k].pal = pal;
				expEntry[k].color = (k % 2 == 1) ? oddPix[k / 2] : evenPix[k / 2];
				if (erased)
					expPa[k] = neoVideoPkg::BACKDROP;
				else if (fixNib != 4'h0)
					expPa[k] = {4'h0, fPal, fixNib};
				else
					expPa[k] = expEntry[k];
				rd = 1'b1;
				s1h1 = (k % 2 == 1);
				fixd = fixByte;
			end
			else
			begin
				rd = 1'b0;
				fixd = 8'h00;
			end
			stepCycle();
		end
	endtask

	task automatic spritePath();
		logic [7:0] pal;
		pal = 8'($random(seed));
		bflip = 1'b0;	// Render A
		sendSprite(pal, 8'($random(seed)));
		writeLine(1'b0);
		bflip = 1'b1;	// Show A
		loadCounters(1'b0);
		readLine(pal, 1'b0, 1'b0, 4'h0);
	endtask

	// Same columns again, all should read back as backdrop
	task automatic eraseBehind();
		loadCounters(1'b0);
		readLine(8'h00, 1'b1, 1'b0, 4'h0);
	endtask

	task automatic fixPriority();
		logic [7:0] pal;
		logic [3:0] fPal;
		pal = 8'($random(seed));
		fPal = 4'($random(seed));
		bflip = 1'b1;	// Render B
		sendSprite(pal, 8'($random(seed)));
		writeLine(1'b1);
		sendFix(fPal);
		bflip = 1'b0;
		loadCounters(1'b1);
		readLine(pal, 1'b0, 1'b1, fPal);
	endtask

	task automatic blankAndCpu();
		logic [11:0] addr;
		chbl = 1'b1;
		stepCycle();
		checkPa(pa, 12'h000, "blanked PA");
		for (int n = 0; n < 4; n++)
		begin
			addr = 12'($random(seed));
			cpu.a22 = 1'b1;	// Palette space
			cpu.addrL = addr;
			cpu.nAs = 1'b0;
			chbl = (n < 2);	// CPU wins over blanking
			stepCycle();
			checkPa(pa, addr, "CPU palette PA");
		end
		setIdle();
		chbl = 1'b1;
		stepCycle();
		checkPa(pa, 12'h000, "blanked PA after CPU");
		chbl = 1'b0;
		stepCycle();
	endtask

	// One-cycle byte write to the kick register
	task automatic kickWatchdog();
		{cpu.a23, cpu.a22, cpu.addrU, cpu.addrL} = neoVideoPkg::WD_KICK_ADDR;
		cpu.rw = 1'b0;
		cpu.nLds = 1'b0;
		cpu.nAs = 1'b0;
		stepCycle();
		setIdle();
	endtask

	task automatic watchdogTimeout();
		int waited;
		for (int n = 0; n < 3; n++)
		begin
			kickWatchdog();
			repeat (1500)
			begin
				stepCycle();
				expectReset(nReset, 1'b1, "nReset while kicked");
			end
		end
		kickWatchdog();
		waited = 1;	// Kick already sampled
		while (nReset === 1'b1 && waited < int'(neoVideoPkg::WD_TIMEOUT) + 2)
		begin
			stepCycle();
			waited++;
		end
		if (nReset !== 1'b0)
		begin
			resetErrors++;
			$display("nReset did not go low within %0d cycles of the last kick", waited);
		end
		else
		begin
			if (waited < int'(neoVideoPkg::WD_TIMEOUT))
				expectReset(1'b0, 1'b1, "nReset before timeout");
			for (int p = 1; p < int'(neoVideoPkg::WD_PULSE); p++)
			begin
				stepCycle();
				expectReset(nReset, 1'b0, "nReset during pulse");
			end
			stepCycle();
			expectReset(nReset, 1'b1, "nReset after pulse");
		end
	endtask

	initial
	begin
		seed = 32'he289_3032;
		paErrors = 0;
		entryErrors = 0;
		resetErrors = 0;
		rst = 1'b1;
		bflip = 1'b0;
		pbus = '0;
		setIdle();
		repeat (4) @(posedge CLK_1MB);
		#10;
		rst = 1'b0;
		repeat (300) stepCycle();	// Line buffer clear sweep
		spritePath();
		eraseBehind();
		fixPriority();
		blankAndCpu();
		watchdogTimeout();
		$display("Errors: pa %0d, entry %0d, reset %0d", paErrors, entryErrors, resetErrors);
		if (paErrors + entryErrors + resetErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* watchdog.sv */
`timescale 1ns/100ps
`default_nettype none

module watchdog (
	input wire CLK_1MB,
	input wire rst,
	input wire neoVideoPkg::cpuBus_t cpu,
	output logic nReset	// To the CPU and system
);

	logic [$bits(neoVideoPkg::WD_TIMEOUT)-1:0] wdCnt;	// Cycles since last kick
	logic [$bits(neoVideoPkg::WD_PULSE)-1:0] pulseCnt;	// Remaining reset cycles
	logic kick;

	// Byte write to the kick register
	assign kick = ~cpu.rw & ~cpu.nLds & ~cpu.nAs
		& ({cpu.a23, cpu.a22, cpu.addrU, cpu.addrL} == neoVideoPkg::WD_KICK_ADDR);

	always_ff @(posedge CLK_1MB)
	begin
		if (rst)
		begin
			wdCnt <= '0;
			pulseCnt <= '0;
			nReset <= 1'b1;
		end
		else if (pulseCnt != '0)
		begin
			pulseCnt <= pulseCnt - 1'b1;	// Kicks ignored during the pulse
			if (pulseCnt == 1)
				nReset <= 1'b1;
		end
		else if (kick)
			wdCnt <= '0;
		else if (wdCnt == neoVideoPkg::WD_TIMEOUT - 1)
		begin
			wdCnt <= '0;	// Count restarts behind the pulse
			pulseCnt <= neoVideoPkg::WD_PULSE;
			nReset <= 1'b0;
		end
		else
			wdCnt <= wdCnt + 1'b1;
	end

endmodule

`default_nettype wire
